// File: logic/cpu_memory_pkg.sv
`default_nettype none

package cpu_memory_pkg;

	//////////////////////////////////////////////////////////////////////
	// Shared vector types
	//////////////////////////////////////////////////////////////////////

	// Register values and bus or cache data
	typedef logic [31:0] word_t;

	// Byte address as seen by the execute stage and the bus
	typedef logic [31:0] address_t;

	// A new operation is signalled by a change of this tag
	typedef logic [7:0] tag_t;

	// Destination register index, carried through to write-back
	typedef logic [4:0] reg_index_t;

	//////////////////////////////////////////////////////////////////////
	// Access width
	//////////////////////////////////////////////////////////////////////

	// Encoded as the number of bytes in the access
	typedef enum logic [2:0] {
		WIDTH_BYTE = 3'd1,
		WIDTH_HALF = 3'd2,
		WIDTH_WORD = 3'd4
	} mem_width_t;

endpackage

`default_nettype wire

// File: logic/cpu_dcache.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_dcache
	import cpu_memory_pkg::*;
#(
	parameter int CACHE_LINES = 16
) (
	input wire i_clock,
	input wire i_reset,

	// Memory stage side
	input wire i_request,
	input wire i_rw,
	input wire i_flush,
	input wire address_t i_address,
	input wire word_t i_wdata,
	output logic o_ready,
	output word_t o_rdata,

	// Bus
	output logic o_bus_request,
	output logic o_bus_rw,
	output address_t o_bus_address,
	output word_t o_bus_wdata,
	input wire i_bus_ready,
	input wire word_t i_bus_rdata
);

	localparam int INDEX_BITS = $clog2(CACHE_LINES);
	localparam int LINE_TAG_BITS = 30 - INDEX_BITS;

	typedef logic [INDEX_BITS-1:0] line_index_t;
	typedef logic [LINE_TAG_BITS-1:0] line_tag_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WRITEBACK,
		FILL,
		FLUSH_SCAN,
		FLUSH_WRITE,
		DONE
	} state_t;

	state_t state;
	word_t data_array [CACHE_LINES];
	line_tag_t tag_array [CACHE_LINES];
	logic [CACHE_LINES-1:0] valid;
	logic [CACHE_LINES-1:0] dirty;
	line_index_t flush_line;

	line_index_t line_index;
	line_tag_t address_tag;
	logic hit;
	logic store_hit;
	logic fill_done;
	logic last_line;

	// One word per line so the index sits right above the byte offset
	assign line_index = i_address[INDEX_BITS+1:2];
	assign address_tag = i_address[31:INDEX_BITS+2];
	assign hit = valid[line_index] && (tag_array[line_index] == address_tag);
	assign store_hit = (state == LOOKUP) && hit && i_rw;
	assign fill_done = (state == FILL) && i_bus_ready;
	assign last_line = (flush_line == line_index_t'(CACHE_LINES - 1));

	assign o_ready = ((state == LOOKUP) && hit) || (state == DONE);
	assign o_rdata = data_array[line_index];

	//////////////////////////////////////////////////////////////////////
	// Bus master
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		o_bus_request = 1'b0;
		o_bus_rw = 1'b0;
		o_bus_address = {address_tag, line_index, 2'b00};
		o_bus_wdata = data_array[line_index];

		case (state)
			WRITEBACK: begin
				o_bus_request = 1'b1;
				o_bus_rw = 1'b1;
				o_bus_address = {tag_array[line_index], line_index, 2'b00};
			end

			FILL: begin
				o_bus_request = 1'b1;
			end

			FLUSH_WRITE: begin
				o_bus_request = 1'b1;
				o_bus_rw = 1'b1;
				o_bus_address = {tag_array[flush_line], flush_line, 2'b00};
				o_bus_wdata = data_array[flush_line];
			end

			default: begin
				o_bus_request = 1'b0;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Control FSM with valid and dirty bits
	//////////////////////////////////////////////////////////////////////

	// Every bus state returns through a state with the request low,
	// so the bus sees the request drop between two transfers
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= IDLE;
			valid <= '0;
			dirty <= '0;
			flush_line <= '0;
		end
		else begin
			case (state)
				IDLE: begin
					if (i_request) begin
						if (i_flush) begin
							flush_line <= '0;
							state <= FLUSH_SCAN;
						end
						else begin
							state <= LOOKUP;
						end
					end
				end

				LOOKUP: begin
					if (hit) begin
						if (i_rw) begin
							dirty[line_index] <= 1'b1;
						end
						state <= IDLE;
					end
					else if (dirty[line_index]) begin
						state <= WRITEBACK;
					end
					else begin
						state <= FILL;
					end
				end

				WRITEBACK: begin
					if (i_bus_ready) begin
						dirty[line_index] <= 1'b0;
						state <= LOOKUP;
					end
				end

				// Look up again after the fill, the access then hits
				FILL: begin
					if (i_bus_ready) begin
						valid[line_index] <= 1'b1;
						dirty[line_index] <= 1'b0;
						state <= LOOKUP;
					end
				end

				FLUSH_SCAN: begin
					if (dirty[flush_line]) begin
						state <= FLUSH_WRITE;
					end
					else if (last_line) begin
						state <= DONE;
					end
					else begin
						flush_line <= flush_line + 1'b1;
					end
				end

				FLUSH_WRITE: begin
					if (i_bus_ready) begin
						dirty[flush_line] <= 1'b0;
						state <= FLUSH_SCAN;
					end
				end

				DONE: begin
					valid <= '0;
					state <= IDLE;
				end

				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (store_hit) begin
			data_array[line_index] <= i_wdata;
		end
		if (fill_done) begin
			data_array[line_index] <= i_bus_rdata;
			tag_array[line_index] <= address_tag;
		end
	end

endmodule

`default_nettype wire

// File: logic/cpu_memory_stage.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_memory_stage
	import cpu_memory_pkg::*;
(
	input wire i_clock,
	input wire i_reset,

	// Execute side
	input wire tag_t i_tag,
	input wire i_mem_read,
	input wire i_mem_write,
	input wire i_mem_flush,
	input wire mem_width_t i_mem_width,
	input wire i_mem_signed,
	input wire address_t i_mem_address,
	input wire word_t i_rd,
	input wire reg_index_t i_inst_rd,

	// Write-back side
	output tag_t o_tag,
	output word_t o_rd,
	output reg_index_t o_inst_rd,
	output logic o_busy,

	// Data cache
	output logic o_cache_request,
	output logic o_cache_rw,
	output logic o_cache_flush,
	output address_t o_cache_address,
	output word_t o_cache_wdata,
	input wire i_cache_ready,
	input wire word_t i_cache_rdata
);

	typedef enum logic [2:0] {
		IDLE,
		READ,
		WRITE_WORD,
		WRITE_RMW_READ,
		WRITE_RMW_WRITE,
		FLUSH
	} state_t;

	state_t state;
	state_t next_state;
	logic new_operation;
	logic complete;
	logic rmw_capture;
	logic [1:0] byte_offset;
	word_t rmw_data;
	word_t lane_shifted;
	word_t load_value;
	word_t merged_word;

	assign new_operation = (i_tag != o_tag);
	assign o_busy = new_operation && (i_mem_read || i_mem_write || i_mem_flush);

	// The cache only ever sees whole words
	assign o_cache_address = {i_mem_address[31:2], 2'b00};
	assign byte_offset = i_mem_address[1:0];

	//////////////////////////////////////////////////////////////////////
	// Load extraction and store merge
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		lane_shifted = i_cache_rdata >> {byte_offset, 3'b000};
		case (i_mem_width)
			WIDTH_BYTE:
				load_value = {{24{i_mem_signed & lane_shifted[7]}}, lane_shifted[7:0]};
			WIDTH_HALF:
				load_value = {{16{i_mem_signed & lane_shifted[15]}}, lane_shifted[15:0]};
			default:
				load_value = i_cache_rdata;
		endcase
	end

	// Replace only the addressed lane of the word read in the first RMW pass
	always_comb begin
		merged_word = rmw_data;
		if (i_mem_width == WIDTH_BYTE) begin
			merged_word[{byte_offset, 3'b000} +: 8] = i_rd[7:0];
		end
		else begin
			merged_word[{byte_offset[1], 4'b0000} +: 16] = i_rd[15:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Operation FSM
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		complete = 1'b0;
		rmw_capture = 1'b0;
		o_cache_request = 1'b0;
		o_cache_rw = 1'b0;
		o_cache_flush = 1'b0;
		o_cache_wdata = i_rd;

		case (state)
			IDLE: begin
				if (new_operation) begin
					if (i_mem_read) begin
						o_cache_request = 1'b1;
						next_state = READ;
					end
					else if (i_mem_write) begin
						o_cache_request = 1'b1;
						if (i_mem_width == WIDTH_WORD) begin
							o_cache_rw = 1'b1;
							next_state = WRITE_WORD;
						end
						else begin
							next_state = WRITE_RMW_READ;
						end
					end
					else if (i_mem_flush) begin
						o_cache_request = 1'b1;
						o_cache_flush = 1'b1;
						next_state = FLUSH;
					end
					else begin
						// No memory access so hand it straight on
						complete = 1'b1;
					end
				end
			end

			READ: begin
				o_cache_request = 1'b1;
				if (i_cache_ready) begin
					complete = 1'b1;
					next_state = IDLE;
				end
			end

			WRITE_WORD: begin
				o_cache_request = 1'b1;
				o_cache_rw = 1'b1;
				if (i_cache_ready) begin
					complete = 1'b1;
					next_state = IDLE;
				end
			end

			WRITE_RMW_READ: begin
				o_cache_request = 1'b1;
				if (i_cache_ready) begin
					rmw_capture = 1'b1;
					next_state = WRITE_RMW_WRITE;
				end
			end

			WRITE_RMW_WRITE: begin
				o_cache_request = 1'b1;
				o_cache_rw = 1'b1;
				o_cache_wdata = merged_word;
				if (i_cache_ready) begin
					complete = 1'b1;
					next_state = IDLE;
				end
			end

			FLUSH: begin
				o_cache_request = 1'b1;
				o_cache_flush = 1'b1;
				if (i_cache_ready) begin
					complete = 1'b1;
					next_state = IDLE;
				end
			end

			default:
				next_state = IDLE;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= IDLE;
			o_tag <= '0;
			o_rd <= '0;
			o_inst_rd <= '0;
		end
		else begin
			state <= next_state;
			if (complete) begin
				o_tag <= i_tag;
				o_rd <= (state == READ) ? load_value : i_rd;
				o_inst_rd <= i_inst_rd;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (rmw_capture) begin
			rmw_data <= i_cache_rdata;
		end
	end

endmodule

`default_nettype wire

// File: logic/cpu_memory_top.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_memory_top
	import cpu_memory_pkg::*;
#(
	parameter int CACHE_LINES = 16
) (
	input wire i_clock,
	input wire i_reset,

	// Execute side
	input wire tag_t i_tag,
	input wire i_mem_read,
	input wire i_mem_write,
	input wire i_mem_flush,
	input wire mem_width_t i_mem_width,
	input wire i_mem_signed,
	input wire address_t i_mem_address,
	input wire word_t i_rd,
	input wire reg_index_t i_inst_rd,

	// Write-back side
	output tag_t o_tag,
	output word_t o_rd,
	output reg_index_t o_inst_rd,
	output logic o_busy,

	// Bus
	output logic o_bus_request,
	output logic o_bus_rw,
	output address_t o_bus_address,
	output word_t o_bus_wdata,
	input wire i_bus_ready,
	input wire word_t i_bus_rdata
);

	logic cache_request;
	logic cache_rw;
	logic cache_flush;
	address_t cache_address;
	word_t cache_wdata;
	logic cache_ready;
	word_t cache_rdata;

	cpu_memory_stage cpu_memory_stage_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_tag(i_tag),
		.i_mem_read(i_mem_read),
		.i_mem_write(i_mem_write),
		.i_mem_flush(i_mem_flush),
		.i_mem_width(i_mem_width),
		.i_mem_signed(i_mem_signed),
		.i_mem_address(i_mem_address),
		.i_rd(i_rd),
		.i_inst_rd(i_inst_rd),
		.o_tag(o_tag),
		.o_rd(o_rd),
		.o_inst_rd(o_inst_rd),
		.o_busy(o_busy),
		.o_cache_request(cache_request),
		.o_cache_rw(cache_rw),
		.o_cache_flush(cache_flush),
		.o_cache_address(cache_address),
		.o_cache_wdata(cache_wdata),
		.i_cache_ready(cache_ready),
		.i_cache_rdata(cache_rdata)
	);

	cpu_dcache #(
		.CACHE_LINES(CACHE_LINES)
	) cpu_dcache_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(cache_request),
		.i_rw(cache_rw),
		.i_flush(cache_flush),
		.i_address(cache_address),
		.i_wdata(cache_wdata),
		.o_ready(cache_ready),
		.o_rdata(cache_rdata),
		.o_bus_request(o_bus_request),
		.o_bus_rw(o_bus_rw),
		.o_bus_address(o_bus_address),
		.o_bus_wdata(o_bus_wdata),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

endmodule

`default_nettype wire

// File: verif/cpu_memory_properties.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_memory_properties (
	input wire i_clock,
	input wire i_reset,
	input wire i_request,
	input wire o_ready,
	input wire o_bus_request,
	input wire [31:0] o_bus_address,
	input wire i_bus_ready
);

	// A bus request holds its level and address until the memory answers
	assert property (@(posedge i_clock) disable iff (i_reset)
		(o_bus_request && !i_bus_ready) |=> (o_bus_request && $stable(o_bus_address)))
		else $error("bus request or address changed before ready");

	assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request |-> (o_bus_address[1:0] == 2'b00))
		else $error("bus address is not word aligned");

	assert property (@(posedge i_clock) disable iff (i_reset)
		o_ready |-> i_request)
		else $error("cache ready without a request");

	// Nothing is requested right after a reset cycle
	assert property (@(posedge i_clock)
		i_reset |=> (!o_bus_request && !o_ready))
		else $error("request seen in the cycle after reset");

endmodule

bind cpu_dcache cpu_memory_properties cpu_memory_properties_i (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_request(i_request),
	.o_ready(o_ready),
	.o_bus_request(o_bus_request),
	.o_bus_address(o_bus_address),
	.i_bus_ready(i_bus_ready)
);

`default_nettype wire

// File: verif/cpu_memory_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_memory_tb
	import cpu_memory_pkg::*;
;

	localparam int TIMEOUT_CYCLES = 2000;

	logic i_clock;
	logic i_reset;
	tag_t i_tag;
	logic i_mem_read;
	logic i_mem_write;
	logic i_mem_flush;
	mem_width_t i_mem_width;
	logic i_mem_signed;
	address_t i_mem_address;
	word_t i_rd;
	reg_index_t i_inst_rd;
	tag_t o_tag;
	word_t o_rd;
	reg_index_t o_inst_rd;
	logic o_busy;
	logic o_bus_request;
	logic o_bus_rw;
	address_t o_bus_address;
	word_t o_bus_wdata;
	logic i_bus_ready;
	word_t i_bus_rdata;

	logic [31:0] lcg_state;
	word_t bus_memory [256];
	word_t shadow [256];
	logic bus_wait_drop;
	logic bus_counting;
	logic [1:0] bus_delay;
	logic [31:0] bus_random;
	int bus_reads;

	// Expected completion as set by the issuing process
	logic pending;
	logic expect_pass;
	tag_t expected_tag;
	word_t expected_rd;
	reg_index_t expected_inst_rd;
	tag_t seen_tag;
	int op_cycles;

	address_t saved_address [8];

	cpu_memory_top #(
		.CACHE_LINES(4)
	) cpu_memory_top_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_tag(i_tag),
		.i_mem_read(i_mem_read),
		.i_mem_write(i_mem_write),
		.i_mem_flush(i_mem_flush),
		.i_mem_width(i_mem_width),
		.i_mem_signed(i_mem_signed),
		.i_mem_address(i_mem_address),
		.i_rd(i_rd),
		.i_inst_rd(i_inst_rd),
		.o_tag(o_tag),
		.o_rd(o_rd),
		.o_inst_rd(o_inst_rd),
		.o_busy(o_busy),
		.o_bus_request(o_bus_request),
		.o_bus_rw(o_bus_rw),
		.o_bus_address(o_bus_address),
		.o_bus_wdata(o_bus_wdata),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	initial begin
		i_clock = 1'b0;
		forever begin
			#50 i_clock = ~i_clock;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic stop_with_failure();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Fail %s: actual %h, expected %h", name, actual, expected);
			stop_with_failure();
		end
	endtask

	// Picks the addressed lane and extends it by sign or by zero
	function automatic word_t expected_load(input word_t word, input logic [1:0] offset,
			input mem_width_t width, input logic is_signed);
		logic [7:0] byte_lane;
		logic [15:0] half_lane;
		word_t result;
		case (offset)
			2'd0: byte_lane = word[7:0];
			2'd1: byte_lane = word[15:8];
			2'd2: byte_lane = word[23:16];
			default: byte_lane = word[31:24];
		endcase
		half_lane = offset[1] ? word[31:16] : word[15:0];
		if (width == WIDTH_BYTE) begin
			result = {{24{is_signed && byte_lane[7]}}, byte_lane};
		end
		else if (width == WIDTH_HALF) begin
			result = {{16{is_signed && half_lane[15]}}, half_lane};
		end
		else begin
			result = word;
		end
		return result;
	endfunction

	task automatic store_lane(input address_t address, input mem_width_t width,
			input word_t data);
		word_t word;
		word = shadow[address[9:2]];
		if (width == WIDTH_WORD) begin
			word = data;
		end
		else if (width == WIDTH_HALF) begin
			if (address[1]) word[31:16] = data[15:0];
			else word[15:0] = data[15:0];
		end
		else begin
			case (address[1:0])
				2'd0: word[7:0] = data[7:0];
				2'd1: word[15:8] = data[7:0];
				2'd2: word[23:16] = data[7:0];
				default: word[31:24] = data[7:0];
			endcase
		end
		shadow[address[9:2]] = word;
	endtask

	function automatic address_t random_address(input mem_width_t width);
		logic [31:0] r;
		address_t address;
		r = lcg_next();
		address = {22'd0, r[9:0]};
		if (width == WIDTH_WORD) address[1:0] = 2'b00;
		if (width == WIDTH_HALF) address[0] = 1'b0;
		return address;
	endfunction

	// Drives one operation under a new tag and waits until it is checked
	task automatic issue_op(input logic rd_op, input logic wr_op, input logic fl_op,
			input mem_width_t width, input logic is_signed, input address_t address,
			input word_t data);
		word_t expected;
		logic [31:0] r;
		tag_t next_tag;
		int cycles;
		expected = data;
		if (rd_op) begin
			expected = expected_load(shadow[address[9:2]], address[1:0], width,
				is_signed);
		end
		if (wr_op) store_lane(address, width, data);
		r = lcg_next();
		@(posedge i_clock);
		next_tag = i_tag + 8'd1;
		i_mem_read <= rd_op;
		i_mem_write <= wr_op;
		i_mem_flush <= fl_op;
		i_mem_width <= width;
		i_mem_signed <= is_signed;
		i_mem_address <= address;
		i_rd <= data;
		i_inst_rd <= r[4:0];
		i_tag <= next_tag;
		expected_tag <= next_tag;
		expected_rd <= expected;
		expected_inst_rd <= r[4:0];
		expect_pass <= !(rd_op || wr_op || fl_op);
		op_cycles <= 0;
		pending <= 1'b1;
		cycles = 0;
		@(posedge i_clock);
		while (pending) begin
			if (cycles == TIMEOUT_CYCLES) begin
				$display("Timeout: operation with tag %h never completed", next_tag);
				stop_with_failure();
			end
			cycles++;
			@(posedge i_clock);
		end
	endtask

	task automatic check_bus_memory();
		for (int i = 0; i < 256; i++) begin
			check_value($sformatf("bus_memory[%0d]", i), bus_memory[i], shadow[i]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bus memory model
	//////////////////////////////////////////////////////////////////////

	task automatic answer_bus();
		i_bus_ready <= 1'b1;
		bus_wait_drop <= 1'b1;
		bus_counting <= 1'b0;
		if (o_bus_rw) begin
			bus_memory[o_bus_address[9:2]] <= o_bus_wdata;
		end
		else begin
			i_bus_rdata <= bus_memory[o_bus_address[9:2]];
			bus_reads <= bus_reads + 1;
		end
	endtask

	always @(posedge i_clock) begin
		i_bus_ready <= 1'b0;
		if (i_reset) begin
			bus_wait_drop <= 1'b0;
			bus_counting <= 1'b0;
		end
		else if (bus_wait_drop) begin
			if (!o_bus_request) bus_wait_drop <= 1'b0;
		end
		else if (o_bus_request) begin
			if (!bus_counting) begin
				bus_random = lcg_next();
				if (bus_random[1:0] == 2'd0) begin
					answer_bus();
				end
				else begin
					bus_counting <= 1'b1;
					bus_delay <= bus_random[1:0];
				end
			end
			else if (bus_delay == 2'd1) begin
				answer_bus();
			end
			else begin
				bus_delay <= bus_delay - 2'd1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checker
	//////////////////////////////////////////////////////////////////////

	always @(posedge i_clock) begin
		if (!i_reset) begin
			if (o_tag != seen_tag) begin
				seen_tag <= o_tag;
				if (!pending) begin
					$display("Error: o_tag changed to %h with no operation outstanding", o_tag);
					stop_with_failure();
				end
				check_value("o_tag", {24'd0, o_tag}, {24'd0, expected_tag});
				check_value("o_rd", o_rd, expected_rd);
				check_value("o_inst_rd", {27'd0, o_inst_rd}, {27'd0, expected_inst_rd});
				if (expect_pass && op_cycles != 1) begin
					$display("Error: pass-through took %0d cycles instead of one", op_cycles);
					stop_with_failure();
				end
				pending <= 1'b0;
			end
			else if (pending) begin
				check_value("o_busy", {31'd0, o_busy}, {31'd0, !expect_pass});
				op_cycles <= op_cycles + 1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		address_t address;
		mem_width_t width;
		int reads_before;
		lcg_state = 32'd71815;
		i_reset = 1'b1;
		i_tag = '0;
		i_mem_read = 1'b0;
		i_mem_write = 1'b0;
		i_mem_flush = 1'b0;
		i_mem_width = WIDTH_WORD;
		i_mem_signed = 1'b0;
		i_mem_address = '0;
		i_rd = '0;
		i_inst_rd = '0;
		i_bus_ready = 1'b0;
		i_bus_rdata = '0;
		bus_reads = 0;
		pending = 1'b0;
		expect_pass = 1'b0;
		seen_tag = '0;
		op_cycles = 0;
		for (int i = 0; i < 256; i++) begin
			bus_memory[i] = {8'(i) ^ 8'hc3, ~8'(i), 8'(i) + 8'h11, 8'(i)};
			shadow[i] = bus_memory[i];
		end
		repeat (3) @(posedge i_clock);
		i_reset <= 1'b0;

		repeat (4) issue_op(1'b0, 1'b0, 1'b0, WIDTH_WORD, 1'b0, '0, lcg_next());

		// With few lines in the cache these addresses evict each other
		for (int i = 0; i < 8; i++) begin
			saved_address[i] = random_address(WIDTH_WORD);
			issue_op(1'b0, 1'b1, 1'b0, WIDTH_WORD, 1'b0, saved_address[i], lcg_next());
		end
		for (int i = 0; i < 8; i++) begin
			issue_op(1'b1, 1'b0, 1'b0, WIDTH_WORD, 1'b0, saved_address[i], '0);
		end

		address = random_address(WIDTH_WORD);
		for (int lane = 0; lane < 4; lane++) begin
			issue_op(1'b0, 1'b1, 1'b0, WIDTH_BYTE, 1'b0, address | 32'(lane), lcg_next());
			issue_op(1'b1, 1'b0, 1'b0, WIDTH_WORD, 1'b0, address, '0);
		end
		for (int lane = 0; lane < 4; lane += 2) begin
			issue_op(1'b0, 1'b1, 1'b0, WIDTH_HALF, 1'b0, address | 32'(lane), lcg_next());
			issue_op(1'b1, 1'b0, 1'b0, WIDTH_WORD, 1'b0, address, '0);
		end

		// Lanes with the top bit set and clear to see both extensions
		issue_op(1'b0, 1'b1, 1'b0, WIDTH_WORD, 1'b0, address, 32'h8f7f_80e1);
		for (int sgn = 0; sgn < 2; sgn++) begin
			for (int lane = 0; lane < 4; lane++) begin
				issue_op(1'b1, 1'b0, 1'b0, WIDTH_BYTE, sgn[0], address | 32'(lane), '0);
			end
			for (int lane = 0; lane < 4; lane += 2) begin
				issue_op(1'b1, 1'b0, 1'b0, WIDTH_HALF, sgn[0], address | 32'(lane), '0);
			end
		end

		issue_op(1'b0, 1'b0, 1'b1, WIDTH_WORD, 1'b0, '0, lcg_next());
		check_bus_memory();
		// The cache holds nothing after a flush so the first load reads the bus once
		for (int i = 0; i < 8; i++) begin
			reads_before = bus_reads;
			issue_op(1'b1, 1'b0, 1'b0, WIDTH_WORD, 1'b0, saved_address[i], '0);
			if (i == 0) begin
				check_value("bus_reads", 32'(bus_reads - reads_before), 32'd1);
			end
		end

		for (int i = 0; i < 80; i++) begin
			r = lcg_next();
			case (r[5:4])
				2'd0: width = WIDTH_BYTE;
				2'd1: width = WIDTH_HALF;
				default: width = WIDTH_WORD;
			endcase
			address = random_address(width);
			case (r[2:0])
				3'd0: issue_op(1'b0, 1'b0, 1'b0, width, r[3], address, lcg_next());
				3'd1, 3'd2, 3'd3: issue_op(1'b1, 1'b0, 1'b0, width, r[3], address, '0);
				3'd7: issue_op(1'b0, 1'b0, 1'b1, width, r[3], address, lcg_next());
				default: issue_op(1'b0, 1'b1, 1'b0, width, r[3], address, lcg_next());
			endcase
		end

		issue_op(1'b0, 1'b0, 1'b1, WIDTH_WORD, 1'b0, '0, lcg_next());
		check_bus_memory();

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: cpu_memory.f
logic/cpu_memory_pkg.sv
logic/cpu_dcache.sv
logic/cpu_memory_stage.sv
logic/cpu_memory_top.sv
verif/cpu_memory_properties.sv
verif/cpu_memory_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cpu_memory_tb -f cpu_memory.f

# The simulator exits non-zero on a fatal check, the search below decides the result
output=$(./obj_dir/Vcpu_memory_tb) || true
echo "$output"

if echo "$output" | grep -q "^Test passed$"; then
	exit 0
fi
exit 1
